// File: Makefile
# Verilator build for the microcoded control unit
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TB_TOP    ?= microcode_sequencer_tb
RTL_TOP   ?= microcode_sequencer
FILELIST  ?= microcode_sequencer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
LINTFLAGS ?= --lint-only --timing --assert
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/microcode_sequencer_assert.sv
// Concurrent checks on the step sequencer, bound into microstep_sequencer
// Needs assertion support enabled in the simulator

`include "microcode_consts.svh"

module microcode_sequencer_assert (
  input logic                         i_clk,
  input logic                         i_reset,
  input microcode_pkg::step_t         i_step,
  input microcode_pkg::control_word_t i_word,
  input logic                         i_halted,
  input logic                         i_xfer_claim,
  input logic                         i_alu_claim
);

  // Set by any failing property
  logic assert_failed = 1'b0;

  adv_restarts: assert property (@(posedge i_clk) disable iff (i_reset)
    i_word[`MC_ADV] |=> i_step == '0)
    else begin
      $error("step did not return to 0 after an ADV word");
      assert_failed = 1'b1;
    end

  // The two decoder groups cover disjoint opcodes
  single_claim: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_xfer_claim && i_alu_claim))
    else begin
      $error("both decoders claimed the same opcode");
      assert_failed = 1'b1;
    end

  halt_frozen: assert property (@(posedge i_clk) disable iff (i_reset)
    i_halted |=> $stable(i_step) && $stable(i_word))
    else begin
      $error("step or control word moved while halted");
      assert_failed = 1'b1;
    end

  step_bound: assert property (@(posedge i_clk) disable iff (i_reset)
    i_step <= 5'd3)
    else begin
      $error("step counter went past 3");
      assert_failed = 1'b1;
    end

endmodule

bind microstep_sequencer microcode_sequencer_assert u_assert (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_step       (o_step),
  .i_word       (o_control_word),
  .i_halted     (o_halted),
  .i_xfer_claim (i_xfer_claim),
  .i_alu_claim  (i_alu_claim)
);

// File: bench/microcode_sequencer_tb.sv
// Table-driven testbench for the microcoded control unit
// Walks each instruction through its micro-steps and compares every control word

`include "microcode_consts.svh"

module microcode_sequencer_tb;

  localparam int WAIT_CYCLES = 20;

  // Single control lines, built from the bit positions
  localparam microcode_pkg::control_word_t C_ADV = 20'd1 << `MC_ADV;
  localparam microcode_pkg::control_word_t C_HLT = 20'd1 << `MC_HLT;
  localparam microcode_pkg::control_word_t C_MI  = 20'd1 << `MC_MI;
  localparam microcode_pkg::control_word_t C_CO  = 20'd1 << `MC_CO;
  localparam microcode_pkg::control_word_t C_RO  = 20'd1 << `MC_RO;
  localparam microcode_pkg::control_word_t C_II  = 20'd1 << `MC_II;
  localparam microcode_pkg::control_word_t C_CE  = 20'd1 << `MC_CE;
  localparam microcode_pkg::control_word_t C_RI  = 20'd1 << `MC_RI;
  localparam microcode_pkg::control_word_t C_J   = 20'd1 << `MC_J;
  localparam microcode_pkg::control_word_t C_ARI = 20'd1 << `MC_ARI;
  localparam microcode_pkg::control_word_t C_ARO = 20'd1 << `MC_ARO;
  localparam microcode_pkg::control_word_t C_BRI = 20'd1 << `MC_BRI;
  localparam microcode_pkg::control_word_t C_BRO = 20'd1 << `MC_BRO;
  localparam microcode_pkg::control_word_t C_TRI = 20'd1 << `MC_TRI;
  localparam microcode_pkg::control_word_t C_TRO = 20'd1 << `MC_TRO;
  localparam microcode_pkg::control_word_t C_EO  = 20'd1 << `MC_EO;
  localparam microcode_pkg::control_word_t C_EL  = 20'd1 << `MC_EL;

  localparam microcode_pkg::control_word_t C_FETCH0 = C_MI | C_CO;
  localparam microcode_pkg::control_word_t C_FETCH1 = C_RO | C_II | C_CE;
  // Operand fetch, shared by loads, stores and jumps
  localparam microcode_pkg::control_word_t C_OPND   = C_MI | C_CO | C_CE;

  logic                         i_clk;
  logic                         i_reset;
  logic [`MC_INSTR_WIDTH-1:0]   i_instruction;
  logic                         i_zero;
  logic                         i_carry;
  microcode_pkg::control_word_t o_control_word;
  microcode_pkg::step_t         o_step;
  logic                         o_halted;

  // Stimulus table, one entry per instruction
  string                        row_name[$];
  logic [`MC_INSTR_WIDTH-1:0]   row_instr[$];
  logic                         row_zero[$];
  logic                         row_carry[$];
  bit                           row_rand[$];
  int                           row_steps[$];
  microcode_pkg::control_word_t row_word2[$];
  microcode_pkg::control_word_t row_word3[$];

  tb_clock_gen #(.PERIOD(40)) u_clock (.o_clk(i_clk));

  microcode_sequencer i_dut (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_instruction  (i_instruction),
    .i_zero         (i_zero),
    .i_carry        (i_carry),
    .o_control_word (o_control_word),
    .o_step         (o_step),
    .o_halted       (o_halted)
  );

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input microcode_pkg::control_word_t expected,
                            input microcode_pkg::control_word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: word expected %h actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_step(input string name, input microcode_pkg::step_t expected,
                            input microcode_pkg::step_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: step expected %0d actual %0d", name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_halted(input string name, input bit expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: halted expected %b actual %b", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Called at a falling edge, returns at a falling edge with the step at 0
  task automatic wait_for_fetch(input string name);
    int cycles;
    cycles = 0;
    while (o_step !== '0) begin
      if (cycles == WAIT_CYCLES) begin
        $display("Timeout in %s: step never returned to 0", name);
        stop_on_failure();
      end
      @(negedge i_clk);
      cycles++;
    end
  endtask

  function automatic microcode_pkg::control_word_t alu_word(input logic [2:0] op);
    return C_EO | C_EL | C_TRI | C_ADV | (microcode_pkg::control_word_t'(op) << `MC_ALU_LSB);
  endfunction

  function automatic microcode_pkg::control_word_t expected_word(input int r, input int k);
    if (k == 0) return C_FETCH0;
    if (k == 1) return C_FETCH1;
    if (k == 2) return row_word2[r];
    return row_word3[r];
  endfunction

  task automatic add_row(input string name, input logic [`MC_INSTR_WIDTH-1:0] instr,
                         input logic zero, input logic carry, input bit rand_flags,
                         input int steps, input microcode_pkg::control_word_t word2,
                         input microcode_pkg::control_word_t word3);
    row_name.push_back(name);
    row_instr.push_back(instr);
    row_zero.push_back(zero);
    row_carry.push_back(carry);
    row_rand.push_back(rand_flags);
    row_steps.push_back(steps);
    row_word2.push_back(word2);
    row_word3.push_back(word3);
  endtask

  task automatic build_table();
    add_row("ld_a", 16'h0001, 1'b0, 1'b0, 1'b1, 4, C_OPND, C_RO | C_ARI | C_ADV);
    add_row("ld_b", 16'h0002, 1'b0, 1'b0, 1'b1, 4, C_OPND, C_RO | C_BRI | C_ADV);
    add_row("ldi_a", 16'h002a, 1'b0, 1'b0, 1'b1, 4, C_OPND, C_RO | C_ARI | C_ADV);
    add_row("ldi_b", 16'h002b, 1'b0, 1'b0, 1'b1, 4, C_OPND, C_RO | C_BRI | C_ADV);
    add_row("st_a", 16'h0004, 1'b0, 1'b0, 1'b1, 4, C_OPND, C_RI | C_ARO | C_ADV);
    add_row("st_b", 16'h0006, 1'b0, 1'b0, 1'b1, 4, C_OPND, C_RI | C_BRO | C_ADV);
    add_row("mov_at", 16'h000e, 1'b0, 1'b0, 1'b1, 3, C_ARO | C_TRI | C_ADV, '0);
    add_row("mov_ab", 16'h000f, 1'b0, 1'b0, 1'b1, 3, C_ARO | C_BRI | C_ADV, '0);
    add_row("mov_ta", 16'h0011, 1'b0, 1'b0, 1'b1, 3, C_TRO | C_ARI | C_ADV, '0);
    add_row("mov_tb", 16'h0012, 1'b0, 1'b0, 1'b1, 3, C_TRO | C_BRI | C_ADV, '0);
    add_row("mov_ba", 16'h0014, 1'b0, 1'b0, 1'b1, 3, C_BRO | C_ARI | C_ADV, '0);
    add_row("mov_bt", 16'h0015, 1'b0, 1'b0, 1'b1, 3, C_BRO | C_TRI | C_ADV, '0);
    add_row("add_b", 16'h0036, 1'b0, 1'b0, 1'b1, 4, C_BRO | C_TRI, alu_word(3'd1));
    add_row("sub_b", 16'h0037, 1'b0, 1'b0, 1'b1, 4, C_BRO | C_TRI, alu_word(3'd2));
    add_row("and_b", 16'h0038, 1'b0, 1'b0, 1'b1, 4, C_BRO | C_TRI, alu_word(3'd3));
    add_row("or_b", 16'h0039, 1'b0, 1'b0, 1'b1, 4, C_BRO | C_TRI, alu_word(3'd4));
    add_row("xor_b", 16'h003a, 1'b0, 1'b0, 1'b1, 4, C_BRO | C_TRI, alu_word(3'd5));
    add_row("inv", 16'h0047, 1'b0, 1'b0, 1'b1, 3, alu_word(3'd6), '0);
    add_row("jmp", 16'h002d, 1'b0, 1'b0, 1'b1, 4, C_OPND, C_RO | C_J | C_ADV);
    // A clear flag ends the jump at step 2, the other flag must not matter
    add_row("jiz_clear", 16'h002e, 1'b0, 1'b1, 1'b0, 3, C_OPND | C_ADV, '0);
    add_row("jiz_set", 16'h002e, 1'b1, 1'b0, 1'b0, 4, C_OPND, C_RO | C_J | C_ADV);
    add_row("jic_clear", 16'h002f, 1'b1, 1'b0, 1'b0, 3, C_OPND | C_ADV, '0);
    add_row("jic_set", 16'h002f, 1'b0, 1'b1, 1'b0, 4, C_OPND, C_RO | C_J | C_ADV);
    add_row("nop_1234", 16'h1234, 1'b0, 1'b0, 1'b1, 3, C_ADV, '0);
    add_row("nop_0003", 16'h0003, 1'b0, 1'b0, 1'b1, 3, C_ADV, '0);
    // Halt stays last, nothing runs after it
    add_row("hlt", 16'hffff, 1'b0, 1'b0, 1'b1, 3, C_HLT, '0);
  endtask

  initial begin : main
    logic [31:0] rnd;
    int          r;
    int          k;

    i_reset       = 1'b1;
    i_instruction = '0;
    i_zero        = 1'b0;
    i_carry       = 1'b0;
    void'($urandom(32'he802_7f87));
    build_table();

    repeat (3) @(posedge i_clk);
    i_reset <= 1'b0;
    @(negedge i_clk);

    for (r = 0; r < row_name.size(); r++) begin
      wait_for_fetch(row_name[r]);
      check_word(row_name[r], C_FETCH0, o_control_word);
      check_halted(row_name[r], 1'b0, o_halted);
      rnd = $urandom;
      @(posedge i_clk);
      i_instruction <= row_instr[r];
      i_zero        <= row_rand[r] ? rnd[0] : row_zero[r];
      i_carry       <= row_rand[r] ? rnd[1] : row_carry[r];
      for (k = 1; k < row_steps[r]; k++) begin
        @(negedge i_clk);
        check_step(row_name[r], microcode_pkg::step_t'(k), o_step);
        check_word(row_name[r], expected_word(r, k), o_control_word);
        check_halted(row_name[r], 1'b0, o_halted);
      end
      if (row_word2[r][`MC_HLT]) begin
        // Changing inputs must not move a halted unit
        repeat (4) begin
          rnd = $urandom;
          @(posedge i_clk);
          i_instruction <= rnd[15:0];
          i_zero        <= rnd[16];
          i_carry       <= rnd[17];
          @(negedge i_clk);
          check_step(row_name[r], 5'd2, o_step);
          check_word(row_name[r], C_HLT, o_control_word);
          check_halted(row_name[r], 1'b1, o_halted);
        end
      end else begin
        @(negedge i_clk);
        check_step(row_name[r], 5'd0, o_step);
      end
    end

    if (i_dut.u_microstep_sequencer.u_assert.assert_failed) begin
      $display("A concurrent assertion failed during the run");
      stop_on_failure();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: bench/tb_clock_gen.sv
// Free-running clock for the testbench
// Starts low, each phase lasts half the period

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

endmodule

// File: hdl/alu_branch_decoder.sv
// Partial control words for the ALU instructions and the jumps
// Conditional jumps finish early when their flag is clear

`include "microcode_consts.svh"

`default_nettype none

module alu_branch_decoder (
  input  wire [`MC_INSTR_WIDTH-1:0]    i_instruction,
  input  wire microcode_pkg::step_t    i_step,
  input  wire                          i_zero,
  input  wire                          i_carry,
  output microcode_pkg::control_word_t o_word,
  output logic                         o_claim
);

  localparam microcode_pkg::step_t STEP_OPERAND = 5'd2;
  localparam microcode_pkg::step_t STEP_DATA    = 5'd3;

  microcode_pkg::alu_op_e alu_op;
  logic                   is_alu_b;
  logic                   is_unary;
  logic                   is_jump;
  logic                   flag_clear;

  // ALU result word, shared by the B forms and INV
  microcode_pkg::control_word_t alu_result;

  always_comb begin
    alu_op     = microcode_pkg::ALU_NONE;
    is_alu_b   = 1'b0;
    is_unary   = 1'b0;
    is_jump    = 1'b0;
    flag_clear = 1'b0;
    case (i_instruction)
      microcode_pkg::OP_ADD_B: begin
        is_alu_b = 1'b1;
        alu_op   = microcode_pkg::ALU_ADD;
      end
      microcode_pkg::OP_SUB_B: begin
        is_alu_b = 1'b1;
        alu_op   = microcode_pkg::ALU_SUB;
      end
      microcode_pkg::OP_AND_B: begin
        is_alu_b = 1'b1;
        alu_op   = microcode_pkg::ALU_AND;
      end
      microcode_pkg::OP_OR_B: begin
        is_alu_b = 1'b1;
        alu_op   = microcode_pkg::ALU_OR;
      end
      microcode_pkg::OP_XOR_B: begin
        is_alu_b = 1'b1;
        alu_op   = microcode_pkg::ALU_XOR;
      end
      microcode_pkg::OP_INV: begin
        is_unary = 1'b1;
        alu_op   = microcode_pkg::ALU_INV;
      end
      microcode_pkg::OP_JMP: is_jump = 1'b1;
      microcode_pkg::OP_JIZ: begin
        is_jump    = 1'b1;
        flag_clear = ~i_zero;
      end
      microcode_pkg::OP_JIC: begin
        is_jump    = 1'b1;
        flag_clear = ~i_carry;
      end
      default: ;
    endcase
  end

  assign o_claim = is_alu_b | is_unary | is_jump;

  always_comb begin
    alu_result          = '0;
    alu_result[`MC_EO]  = 1'b1;
    alu_result[`MC_EL]  = 1'b1;
    alu_result[`MC_TRI] = 1'b1;
    alu_result[`MC_ADV] = 1'b1;
    alu_result[`MC_ALU_LSB +: $bits(microcode_pkg::alu_op_e)] = alu_op;
  end

  always_comb begin
    o_word = '0;
    if (is_alu_b) begin
      // B goes to T first, then the ALU combines A with T back into T
      if (i_step == STEP_OPERAND) begin
        o_word[`MC_BRO] = 1'b1;
        o_word[`MC_TRI] = 1'b1;
      end else if (i_step == STEP_DATA) begin
        o_word = alu_result;
      end
    end else if (is_unary) begin
      if (i_step == STEP_OPERAND) begin
        o_word = alu_result;
      end
    end else if (is_jump) begin
      if (i_step == STEP_OPERAND) begin
        o_word[`MC_MI]  = 1'b1;
        o_word[`MC_CO]  = 1'b1;
        o_word[`MC_CE]  = 1'b1;
        // Not taken, so the target word is skipped and the instruction ends
        o_word[`MC_ADV] = flag_clear;
      end else if (i_step == STEP_DATA) begin
        o_word[`MC_RO]  = 1'b1;
        o_word[`MC_J]   = 1'b1;
        o_word[`MC_ADV] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/microcode_consts.svh
// Widths and control word bit positions for the microcoded control unit
// Include this before naming any control word bit or bus width

`ifndef MICROCODE_CONSTS_SVH
`define MICROCODE_CONSTS_SVH

// Instruction word and step counter widths
`define MC_INSTR_WIDTH 16
`define MC_STEP_WIDTH  5

// Total control word width, including the 3-bit ALU operation field
`define MC_CW_WIDTH    20

// Sequencing bits
`define MC_ADV 0
`define MC_HLT 1

// Memory address, program counter and instruction register controls
`define MC_MI  2
`define MC_CO  3
`define MC_RO  4
`define MC_II  5
`define MC_CE  6
`define MC_RI  7
`define MC_J   8

// Register file strobes, in for load and out for bus drive
`define MC_ARI 9
`define MC_ARO 10
`define MC_BRI 11
`define MC_BRO 12
`define MC_TRI 13
`define MC_TRO 14

// ALU output enable and flag latch
`define MC_EO  15
`define MC_EL  16

// The ALU operation occupies bits 17 to 19
`define MC_ALU_LSB 17

`endif

// File: hdl/microcode_pkg.sv
// Types shared by the microcode decoders and the step sequencer
// Referenced with scoped names from every block of the control unit

`include "microcode_consts.svh"

package microcode_pkg;

  // One complete set of control lines for a single micro-step
  typedef logic [`MC_CW_WIDTH-1:0] control_word_t;

  // Micro-step number within the current instruction
  typedef logic [`MC_STEP_WIDTH-1:0] step_t;

  // Opcodes handled by this control unit, everything else runs as NOP
  typedef enum logic [`MC_INSTR_WIDTH-1:0] {
    OP_LD_A   = 16'h0001,
    OP_LD_B   = 16'h0002,
    OP_ST_A   = 16'h0004,
    OP_ST_B   = 16'h0006,
    OP_MOV_AT = 16'h000e,
    OP_MOV_AB = 16'h000f,
    OP_MOV_TA = 16'h0011,
    OP_MOV_TB = 16'h0012,
    OP_MOV_BA = 16'h0014,
    OP_MOV_BT = 16'h0015,
    OP_LDI_A  = 16'h002a,
    OP_LDI_B  = 16'h002b,
    OP_JMP    = 16'h002d,
    OP_JIZ    = 16'h002e,
    OP_JIC    = 16'h002f,
    OP_ADD_B  = 16'h0036,
    OP_SUB_B  = 16'h0037,
    OP_AND_B  = 16'h0038,
    OP_OR_B   = 16'h0039,
    OP_XOR_B  = 16'h003a,
    OP_INV    = 16'h0047,
    OP_HLT    = 16'hffff
  } opcode_e;

  // Encoding of the ALU operation field in the control word
  typedef enum logic [2:0] {
    ALU_NONE = 3'd0,
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_OR   = 3'd4,
    ALU_XOR  = 3'd5,
    ALU_INV  = 3'd6
  } alu_op_e;

endpackage

// File: hdl/microcode_sequencer.sv
// Top level of the microcoded control unit
// Both decoders see the same step and opcode, the sequencer merges their words

`include "microcode_consts.svh"

`default_nettype none

module microcode_sequencer (
  input  wire                          i_clk,
  input  wire                          i_reset,
  input  wire [`MC_INSTR_WIDTH-1:0]    i_instruction,
  input  wire                          i_zero,
  input  wire                          i_carry,
  output microcode_pkg::control_word_t o_control_word,
  output microcode_pkg::step_t         o_step,
  output logic                         o_halted
);

  microcode_pkg::control_word_t xfer_word;
  microcode_pkg::control_word_t alu_word;
  logic                         xfer_claim;
  logic                         alu_claim;

  transfer_decoder u_transfer_decoder (
    .i_instruction (i_instruction),
    .i_step        (o_step),
    .o_word        (xfer_word),
    .o_claim       (xfer_claim)
  );

  alu_branch_decoder u_alu_branch_decoder (
    .i_instruction (i_instruction),
    .i_step        (o_step),
    .i_zero        (i_zero),
    .i_carry       (i_carry),
    .o_word        (alu_word),
    .o_claim       (alu_claim)
  );

  microstep_sequencer u_microstep_sequencer (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_xfer_word    (xfer_word),
    .i_xfer_claim   (xfer_claim),
    .i_alu_word     (alu_word),
    .i_alu_claim    (alu_claim),
    .o_step         (o_step),
    .o_control_word (o_control_word),
    .o_halted       (o_halted)
  );

endmodule

`default_nettype wire

// File: hdl/microstep_sequencer.sv
// Step counter and halt state of the control unit
// Emits the fetch words itself and merges the decoder words from step 2 on

`include "microcode_consts.svh"

`default_nettype none

module microstep_sequencer (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire microcode_pkg::control_word_t i_xfer_word,
  input  wire                           i_xfer_claim,
  input  wire microcode_pkg::control_word_t i_alu_word,
  input  wire                           i_alu_claim,
  output microcode_pkg::step_t          o_step,
  output microcode_pkg::control_word_t  o_control_word,
  output logic                          o_halted
);

  localparam microcode_pkg::step_t STEP_FETCH_ADDR  = 5'd0;
  localparam microcode_pkg::step_t STEP_FETCH_INSTR = 5'd1;
  localparam microcode_pkg::step_t STEP_FIRST_EXEC  = 5'd2;

  microcode_pkg::step_t         step_q;
  logic                         halted_q;
  microcode_pkg::control_word_t word;

  always_comb begin
    word = '0;
    if (halted_q) begin
      // Parked on HLT, the word stays put whatever the inputs do
      word[`MC_HLT] = 1'b1;
    end else if (step_q == STEP_FETCH_ADDR) begin
      word[`MC_MI] = 1'b1;
      word[`MC_CO] = 1'b1;
    end else if (step_q == STEP_FETCH_INSTR) begin
      word[`MC_RO] = 1'b1;
      word[`MC_II] = 1'b1;
      word[`MC_CE] = 1'b1;
    end else begin
      word = i_xfer_word | i_alu_word;
      // Opcodes neither decoder knows run as a one-step NOP
      if (step_q == STEP_FIRST_EXEC && !i_xfer_claim && !i_alu_claim) begin
        word[`MC_ADV] = 1'b1;
      end
    end
  end

  // ADV wins over HLT, and a halted unit only leaves through reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      step_q   <= STEP_FETCH_ADDR;
      halted_q <= 1'b0;
    end else if (word[`MC_ADV]) begin
      step_q <= STEP_FETCH_ADDR;
    end else if (word[`MC_HLT]) begin
      halted_q <= 1'b1;
    end else begin
      step_q <= step_q + 5'd1;
    end
  end

  assign o_step         = step_q;
  assign o_control_word = word;
  assign o_halted       = halted_q;

endmodule

`default_nettype wire

// File: hdl/transfer_decoder.sv
// Partial control words for loads, stores, register moves and halt
// Drives nothing during fetch, the sequencer owns steps 0 and 1

`include "microcode_consts.svh"

`default_nettype none

module transfer_decoder (
  input  wire [`MC_INSTR_WIDTH-1:0]    i_instruction,
  input  wire microcode_pkg::step_t    i_step,
  output microcode_pkg::control_word_t o_word,
  output logic                         o_claim
);

  localparam microcode_pkg::step_t STEP_OPERAND = 5'd2;
  localparam microcode_pkg::step_t STEP_DATA    = 5'd3;

  // Instruction group flags
  logic is_load;
  logic is_store;
  logic is_move;
  logic is_halt;

  // Register output and input strobes selected by the opcode
  microcode_pkg::control_word_t reg_out;
  microcode_pkg::control_word_t reg_in;

  // LD and LDI share microcode, both read the word after the opcode
  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    is_move  = 1'b0;
    is_halt  = 1'b0;
    reg_out  = '0;
    reg_in   = '0;
    case (i_instruction)
      microcode_pkg::OP_LD_A, microcode_pkg::OP_LDI_A: begin
        is_load         = 1'b1;
        reg_in[`MC_ARI] = 1'b1;
      end
      microcode_pkg::OP_LD_B, microcode_pkg::OP_LDI_B: begin
        is_load         = 1'b1;
        reg_in[`MC_BRI] = 1'b1;
      end
      microcode_pkg::OP_ST_A: begin
        is_store         = 1'b1;
        reg_out[`MC_ARO] = 1'b1;
      end
      microcode_pkg::OP_ST_B: begin
        is_store         = 1'b1;
        reg_out[`MC_BRO] = 1'b1;
      end
      microcode_pkg::OP_MOV_AT: begin
        is_move          = 1'b1;
        reg_out[`MC_ARO] = 1'b1;
        reg_in[`MC_TRI]  = 1'b1;
      end
      microcode_pkg::OP_MOV_AB: begin
        is_move          = 1'b1;
        reg_out[`MC_ARO] = 1'b1;
        reg_in[`MC_BRI]  = 1'b1;
      end
      microcode_pkg::OP_MOV_TA: begin
        is_move          = 1'b1;
        reg_out[`MC_TRO] = 1'b1;
        reg_in[`MC_ARI]  = 1'b1;
      end
      microcode_pkg::OP_MOV_TB: begin
        is_move          = 1'b1;
        reg_out[`MC_TRO] = 1'b1;
        reg_in[`MC_BRI]  = 1'b1;
      end
      microcode_pkg::OP_MOV_BA: begin
        is_move          = 1'b1;
        reg_out[`MC_BRO] = 1'b1;
        reg_in[`MC_ARI]  = 1'b1;
      end
      microcode_pkg::OP_MOV_BT: begin
        is_move          = 1'b1;
        reg_out[`MC_BRO] = 1'b1;
        reg_in[`MC_TRI]  = 1'b1;
      end
      microcode_pkg::OP_HLT: is_halt = 1'b1;
      default: ;
    endcase
  end

  assign o_claim = is_load | is_store | is_move | is_halt;

  always_comb begin
    o_word = '0;
    if (is_load || is_store) begin
      if (i_step == STEP_OPERAND) begin
        // Point memory at the operand word and step the PC past it
        o_word[`MC_MI] = 1'b1;
        o_word[`MC_CO] = 1'b1;
        o_word[`MC_CE] = 1'b1;
      end else if (i_step == STEP_DATA) begin
        o_word          = reg_out | reg_in;
        o_word[`MC_RO]  = is_load;
        o_word[`MC_RI]  = is_store;
        o_word[`MC_ADV] = 1'b1;
      end
    end else if (is_move) begin
      if (i_step == STEP_OPERAND) begin
        o_word          = reg_out | reg_in;
        o_word[`MC_ADV] = 1'b1;
      end
    end else if (is_halt) begin
      // No ADV here, so the sequencer parks on this step
      if (i_step == STEP_OPERAND) begin
        o_word[`MC_HLT] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: microcode_sequencer.f
+incdir+hdl
hdl/microcode_pkg.sv
hdl/transfer_decoder.sv
hdl/alu_branch_decoder.sv
hdl/microstep_sequencer.sv
hdl/microcode_sequencer.sv
bench/tb_clock_gen.sv
bench/microcode_sequencer_assert.sv
bench/microcode_sequencer_tb.sv
